//--- commutationSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module commutationSequencer (
    input  wire                                  clk,
    input  wire                                  rstN,
    input  wire                                  runEn,
    output logic                                 periodStart,
    output logic                                 frameStart,
    output logic                                 frameLast,
    output logic [motorPwmPkg::SECTOR_W-1:0]     sector
);

    // cycle position inside the running period
    logic [motorPwmPkg::CYCLE_W-1:0] cycleCnt;
    // index of the next period to begin within the frame
    logic [motorPwmPkg::FRAME_W-1:0] periodIdx;
    logic                            cycleWrap;
    logic                            cycleEnd;

    assign cycleWrap = (cycleCnt == '0);
    assign cycleEnd  = (cycleCnt == motorPwmPkg::CYCLE_LAST);

    // strobes are registered, so the first periodStart trails runEn by one cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cycleCnt    <= '0;
            periodIdx   <= '0;
            periodStart <= 1'b0;
            frameStart  <= 1'b0;
            frameLast   <= 1'b0;
        end else if (!runEn) begin
            // parked, next run restarts a clean frame
            cycleCnt    <= '0;
            periodIdx   <= '0;
            periodStart <= 1'b0;
            frameStart  <= 1'b0;
            frameLast   <= 1'b0;
        end else begin
            cycleCnt    <= cycleEnd ? '0 : cycleCnt + 1'b1;
            periodStart <= cycleWrap;
            frameStart  <= cycleWrap && (periodIdx == '0);
            // periodIdx already wrapped to 0 while the frame's last period runs
            frameLast   <= cycleEnd && (periodIdx == '0);
            if (cycleWrap) begin
                periodIdx <= (periodIdx == motorPwmPkg::FRAME_LAST) ? '0 : periodIdx + 1'b1;
            end
        end
    end

    // six-step rotation, one step per frame
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sector <= '0;
        end else if (frameLast) begin
            sector <= (sector == motorPwmPkg::SECTOR_LAST) ? '0 : sector + 1'b1;
        end
    end

    sectorInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        sector <= motorPwmPkg::SECTOR_LAST
    ) else $error("sector out of range");

endmodule

`default_nettype wire

//--- dutyCmdReceiver.sv
`timescale 1ns/10ps
`default_nettype none

module dutyCmdReceiver (
    input  wire                                  clk,
    input  wire                                  rstN,
    input  wire                                  cmdReq,
    input  wire [motorPwmPkg::PHASE_W-1:0]       cmdPhase,
    input  wire [motorPwmPkg::DUTY_W-1:0]        cmdDuty,
    output logic                                 cmdAck,
    output logic                                 wrEn,
    output logic [motorPwmPkg::PHASE_W-1:0]      wrPhase,
    output logic [motorPwmPkg::DUTY_W-1:0]       wrDuty
);

    // new request seen while idle
    logic                              reqNew;
    logic [motorPwmPkg::DUTY_W-1:0]    dutyClamped;

    assign reqNew = cmdReq && !cmdAck;

    // duty saturates at the largest value a carried pulse can still absorb
    assign dutyClamped = (cmdDuty > motorPwmPkg::MAX_DUTY) ? motorPwmPkg::MAX_DUTY : cmdDuty;

    // four-phase ack: up after req high, down after req low
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cmdAck <= 1'b0;
            wrEn   <= 1'b0;
        end else begin
            if (reqNew) begin
                cmdAck <= 1'b1;
            end else if (!cmdReq) begin
                cmdAck <= 1'b0;
            end
            // single write strobe, aligned with the rising ack
            wrEn <= reqNew;
        end
    end

    // payload captured once per handshake
    // phase 3 goes through untouched, the buffer drops it
    always_ff @(posedge clk) begin
        if (reqNew) begin
            wrPhase <= cmdPhase;
            wrDuty  <= dutyClamped;
        end
    end

    // ack only ever answers a request that was already up
    ackAfterReq: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(cmdAck) |-> $past(cmdReq)
    ) else $error("cmdAck rose without cmdReq");

endmodule

`default_nettype wire

//--- dutyShadowBuffer.sv
`timescale 1ns/10ps
`default_nettype none

module dutyShadowBuffer (
    input  wire                                  clk,
    input  wire                                  rstN,
    input  wire                                  wrEn,
    input  wire [motorPwmPkg::PHASE_W-1:0]       wrPhase,
    input  wire [motorPwmPkg::DUTY_W-1:0]        wrDuty,
    input  wire                                  frameLast,
    output logic [motorPwmPkg::DUTY_W-1:0]       dutyA,
    output logic [motorPwmPkg::DUTY_W-1:0]       dutyB,
    output logic [motorPwmPkg::DUTY_W-1:0]       dutyC
);

    // index 0..2 maps to phases A..C
    logic [2:0][motorPwmPkg::DUTY_W-1:0] pending;
    logic [2:0][motorPwmPkg::DUTY_W-1:0] active;

    // commands land in pending at any time
    // active only moves on the last cycle of a frame
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending <= '0;
            active  <= '0;
        end else begin
            for (int p = 0; p < 3; p++) begin
                // phase 3 matches no slot and is dropped
                if (wrEn && int'(wrPhase) == p) begin
                    pending[p] <= wrDuty;
                end
            end
            // a write on the same edge is too late for this swap
            if (frameLast) begin
                active <= pending;
            end
        end
    end

    assign dutyA = active[0];
    assign dutyB = active[1];
    assign dutyC = active[2];

endmodule

`default_nettype wire

//--- motorPwmPkg.sv
`default_nettype none

package motorPwmPkg;

    // duty and pulse length width
    localparam int DUTY_W = 8;

    // clock cycles per pwm period and its counter width
    localparam int PWM_PERIOD = 256;
    localparam int CYCLE_W = $clog2(PWM_PERIOD);

    // pwm periods per commutation frame
    localparam int FRAME_PERIODS = 4;
    localparam int FRAME_W = $clog2(FRAME_PERIODS);

    // six-step commutation
    localparam int SECTOR_COUNT = 6;
    localparam int SECTOR_W = 3;

    // phase select on the command port, index 3 is a dummy slot
    localparam int PHASE_W = 2;

    // shortest gate-on time the driver can take
    localparam logic [DUTY_W-1:0] MIN_PULSE = 8'd16;
    // MAX_DUTY + MIN_PULSE - 1 still fits inside one period
    localparam logic [DUTY_W-1:0] MAX_DUTY = 8'd239;

    // wrap points of the sequencer counters
    localparam logic [CYCLE_W-1:0] CYCLE_LAST = CYCLE_W'(PWM_PERIOD - 1);
    localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(FRAME_PERIODS - 1);
    localparam logic [SECTOR_W-1:0] SECTOR_LAST = SECTOR_W'(SECTOR_COUNT - 1);

    // phase left floating in a sector: sectors 0/3 float A, 1/4 float B, 2/5 float C
    function automatic logic isFloating(input logic [SECTOR_W-1:0] sector, input int phaseIdx);
        return (int'(sector) % 3) == phaseIdx;
    endfunction

endpackage

`default_nettype wire

//--- motorPwmTop.sv
`timescale 1ns/10ps
`default_nettype none

module motorPwmTop (
    input  wire                                  clk,
    input  wire                                  rstN,
    input  wire                                  runEn,
    input  wire                                  cmdReq,
    input  wire [motorPwmPkg::PHASE_W-1:0]       cmdPhase,
    input  wire [motorPwmPkg::DUTY_W-1:0]        cmdDuty,
    output logic                                 cmdAck,
    output logic                                 pwmA,
    output logic                                 pwmB,
    output logic                                 pwmC,
    output logic [motorPwmPkg::SECTOR_W-1:0]     sector,
    output logic                                 periodStart,
    output logic                                 frameStart
);

    // receiver to shadow buffer
    logic                              wrEn;
    logic [motorPwmPkg::PHASE_W-1:0]   wrPhase;
    logic [motorPwmPkg::DUTY_W-1:0]    wrDuty;
    // sequencer frame end, swaps duties and steps the sector
    logic                              frameLast;
    // active duties per phase
    logic [motorPwmPkg::DUTY_W-1:0]    dutyA;
    logic [motorPwmPkg::DUTY_W-1:0]    dutyB;
    logic [motorPwmPkg::DUTY_W-1:0]    dutyC;

    dutyCmdReceiver uRx (
        .clk(clk), .rstN(rstN),
        .cmdReq(cmdReq), .cmdPhase(cmdPhase), .cmdDuty(cmdDuty), .cmdAck(cmdAck),
        .wrEn(wrEn), .wrPhase(wrPhase), .wrDuty(wrDuty)
    );

    dutyShadowBuffer uBuf (
        .clk(clk), .rstN(rstN),
        .wrEn(wrEn), .wrPhase(wrPhase), .wrDuty(wrDuty), .frameLast(frameLast),
        .dutyA(dutyA), .dutyB(dutyB), .dutyC(dutyC)
    );

    commutationSequencer uSeq (
        .clk(clk), .rstN(rstN), .runEn(runEn),
        .periodStart(periodStart), .frameStart(frameStart),
        .frameLast(frameLast), .sector(sector)
    );

    // one generator per bridge leg
    phasePwmGenerator #(.PHASE_INDEX(0)) uGenA (
        .clk(clk), .rstN(rstN), .periodStart(periodStart),
        .sector(sector), .duty(dutyA), .pwm(pwmA)
    );

    phasePwmGenerator #(.PHASE_INDEX(1)) uGenB (
        .clk(clk), .rstN(rstN), .periodStart(periodStart),
        .sector(sector), .duty(dutyB), .pwm(pwmB)
    );

    phasePwmGenerator #(.PHASE_INDEX(2)) uGenC (
        .clk(clk), .rstN(rstN), .periodStart(periodStart),
        .sector(sector), .duty(dutyC), .pwm(pwmC)
    );

endmodule

`default_nettype wire

//--- phasePwmGenerator.sv
`timescale 1ns/10ps
`default_nettype none

module phasePwmGenerator #(
    // 0 = A, 1 = B, 2 = C
    parameter int PHASE_INDEX = 0
) (
    input  wire                                  clk,
    input  wire                                  rstN,
    input  wire                                  periodStart,
    input  wire [motorPwmPkg::SECTOR_W-1:0]      sector,
    input  wire [motorPwmPkg::DUTY_W-1:0]        duty,
    output logic                                 pwm
);

    // on-time held back from periods that were too short
    logic [motorPwmPkg::DUTY_W-1:0] carryRem;
    // remaining high cycles of the current pulse
    logic [motorPwmPkg::DUTY_W-1:0] pulseCnt;
    // carry + new duty, bounded by MAX_DUTY + MIN_PULSE - 1
    logic [motorPwmPkg::DUTY_W-1:0] sum;
    logic                           floating;
    logic                           loadPulse;

    assign sum = carryRem + duty;

    // this phase is off the bridge for the whole sector
    assign floating = motorPwmPkg::isFloating(sector, PHASE_INDEX);

    // only pulses the gate driver can actually follow
    assign loadPulse = periodStart && !floating && (sum >= motorPwmPkg::MIN_PULSE);

    // carry decision once per period
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            carryRem <= '0;
        end else if (periodStart) begin
            if (floating || loadPulse) begin
                // floating phase loses its debt, a fired pulse paid it
                carryRem <= '0;
            end else begin
                // too short, push everything into the next period
                carryRem <= sum;
            end
        end
    end

    // down-counter, pulse starts the cycle after periodStart
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pulseCnt <= '0;
        end else if (loadPulse) begin
            pulseCnt <= sum;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    // high exactly as long as the counter runs
    assign pwm = (pulseCnt != '0);

    // a floating phase stays quiet at period start
    floatSilent: assert property (
        @(posedge clk) disable iff (!rstN)
        periodStart && floating |=> !pwm
    ) else $error("pwm high on floating phase %0d", PHASE_INDEX);

    // every pulse lasts at least the minimum gate-on time
    minPulseWidth: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(pwm) |-> pwm [*motorPwmPkg::MIN_PULSE]
    ) else $error("short pulse on phase %0d", PHASE_INDEX);

endmodule

`default_nettype wire

//--- runSim.sh
#!/usr/bin/env bash
# compile and run the motor pwm testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tbMotorPwm -o simMotorPwm

simOut="$(./obj_dir/simMotorPwm)"
echo "$simOut"

if grep -qx "ALL TESTS PASSED" <<< "$simOut"; then
    exit 0
else
    exit 1
fi

//--- sources.f
motorPwmPkg.sv
dutyCmdReceiver.sv
dutyShadowBuffer.sv
commutationSequencer.sv
phasePwmGenerator.sv
motorPwmTop.sv
tbMotorPwm.sv

//--- tbMotorPwm.sv
`timescale 1ns/10ps
`default_nettype none

module tbMotorPwm;

    localparam int HS_TIMEOUT = 64;
    localparam int FRAME_TIMEOUT = 2 * motorPwmPkg::FRAME_PERIODS * motorPwmPkg::PWM_PERIOD;

    logic clk = 1'b0;
    logic rstN;
    logic runEn;
    logic cmdReq;
    logic [motorPwmPkg::PHASE_W-1:0] cmdPhase;
    logic [motorPwmPkg::DUTY_W-1:0] cmdDuty;
    logic cmdAck;
    logic pwmA;
    logic pwmB;
    logic pwmC;
    logic [motorPwmPkg::SECTOR_W-1:0] sector;
    logic periodStart;
    logic frameStart;
    logic [2:0] pwmVec;

    // reference model of pending and active duties, carry and sector
    logic [7:0] pendM [3];
    logic [7:0] pendLag [3];
    logic [7:0] activeM [3];
    int carryM [3];
    int expLen [3];
    int widthCnt [3];
    int sectorM;
    int framesSeen;
    int periodsSeen;
    logic reqLast;
    logic mWrEn;
    logic [1:0] mWrPhase;
    logic [7:0] mWrDuty;
    // running cycles since runEn went high, and the strobes they imply
    int runCycles;
    logic expPeriod;
    logic expFrame;

    logic [15:0] lfsrState = 16'd15;
    int errCount = 0;
    int testErrBase = 0;
    int testsRun = 0;
    int testsFailed = 0;
    logic timedOut = 1'b0;

    motorPwmTop DUT (
        .clk(clk), .rstN(rstN), .runEn(runEn),
        .cmdReq(cmdReq), .cmdPhase(cmdPhase), .cmdDuty(cmdDuty), .cmdAck(cmdAck),
        .pwmA(pwmA), .pwmB(pwmB), .pwmC(pwmC), .sector(sector),
        .periodStart(periodStart), .frameStart(frameStart)
    );

    assign pwmVec = {pwmC, pwmB, pwmA};

    always #4 clk = ~clk;

    // galois lfsr, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [7:0] randBits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    function automatic logic [7:0] clampDuty(input logic [7:0] d);
        return (d > motorPwmPkg::MAX_DUTY) ? motorPwmPkg::MAX_DUTY : d;
    endfunction

    function automatic string phaseName(input int p);
        return (p == 0) ? "A" : ((p == 1) ? "B" : "C");
    endfunction

    always @(posedge clk) begin : refModel
        int secNow;
        int sum;
        logic [7:0] actNow [3];
        if (!rstN) begin
            for (int p = 0; p < 3; p++) begin
                pendM[p] <= '0;
                pendLag[p] <= '0;
                activeM[p] <= '0;
                carryM[p] <= 0;
                expLen[p] <= 0;
                widthCnt[p] <= 0;
            end
            sectorM <= 0;
            framesSeen <= 0;
            periodsSeen <= 0;
            reqLast <= 1'b0;
            mWrEn <= 1'b0;
            runCycles <= 0;
            expPeriod <= 1'b0;
            expFrame <= 1'b0;
        end else begin
            reqLast <= cmdReq;
            // a period every PWM_PERIOD running cycles, a frame every FRAME_PERIODS periods
            expPeriod <= runEn && (runCycles % motorPwmPkg::PWM_PERIOD == 0);
            expFrame <= runEn && (runCycles %
                (motorPwmPkg::PWM_PERIOD * motorPwmPkg::FRAME_PERIODS) == 0);
            runCycles <= runEn ? runCycles + 1 : 0;
            // write cycle is the one where ack rises, it lands in pending at its end
            mWrEn <= cmdReq && !reqLast;
            if (cmdReq && !reqLast) begin
                mWrPhase <= cmdPhase;
                mWrDuty <= clampDuty(cmdDuty);
            end
            if (mWrEn && mWrPhase != 2'd3) begin
                pendM[mWrPhase] <= mWrDuty;
            end
            pendLag <= pendM;
            for (int p = 0; p < 3; p++) begin
                if (pwmVec[p]) begin
                    widthCnt[p] <= widthCnt[p] + 1;
                end
            end
            if (expPeriod) begin
                secNow = sectorM;
                actNow = activeM;
                // the very first frame runs on reset duties and sector 0
                if (expFrame && framesSeen > 0) begin
                    secNow = (sectorM + 1) % motorPwmPkg::SECTOR_COUNT;
                    actNow = pendLag;
                end
                if (expFrame) begin
                    framesSeen <= framesSeen + 1;
                end
                sectorM <= secNow;
                activeM <= actNow;
                periodsSeen <= periodsSeen + 1;
                for (int p = 0; p < 3; p++) begin
                    sum = carryM[p] + int'(actNow[p]);
                    widthCnt[p] <= 0;
                    if (secNow % 3 == p) begin
                        carryM[p] <= 0;
                        expLen[p] <= 0;
                    end else if (sum < int'(motorPwmPkg::MIN_PULSE)) begin
                        carryM[p] <= sum;
                        expLen[p] <= 0;
                    end else begin
                        carryM[p] <= 0;
                        expLen[p] <= sum;
                    end
                end
            end
        end
    end

    // four-phase slave: ack mirrors req one cycle late
    ackFollowsReq: assert property (@(posedge clk) disable iff (!rstN) cmdAck == reqLast)
        else begin
            $display("FAIL cmdAck expected %h got %h", $sampled(reqLast), $sampled(cmdAck));
            errCount++;
        end

    // parked sequencer, all outputs quiet
    idleQuiet: assert property (@(posedge clk) disable iff (!rstN)
        !runEn |-> {periodStart, frameStart, pwmVec, sector} == '0)
        else begin
            $display("FAIL idle outputs expected %h got %h", 8'h00,
                     $sampled({periodStart, frameStart, pwmVec, sector}));
            errCount++;
        end

    // period and frame strobes placed by run time alone
    strobeTiming: assert property (@(posedge clk) disable iff (!rstN)
        {periodStart, frameStart} == {expPeriod, expFrame})
        else begin
            $display("FAIL {periodStart,frameStart} expected %h got %h",
                     $sampled({expPeriod, expFrame}), $sampled({periodStart, frameStart}));
            errCount++;
        end

    sectorStep: assert property (@(posedge clk) disable iff (!rstN)
        expPeriod |=> int'(sector) == sectorM)
        else begin
            $display("FAIL sector expected %h got %h", $sampled(sectorM), $sampled(sector));
            errCount++;
        end

    // width of the period just ended, checked at the next boundary
    for (genvar p = 0; p < 3; p++) begin : widthCheck
        pulseWidth: assert property (@(posedge clk) disable iff (!rstN)
            expPeriod && periodsSeen > 0 |-> widthCnt[p] == expLen[p])
            else begin
                $display("FAIL pwm%s width expected %h got %h", phaseName(p),
                         $sampled(expLen[p]), $sampled(widthCnt[p]));
                errCount++;
            end
    end

    task automatic sendCmd(input logic [1:0] phase, input logic [7:0] duty);
        int n;
        if (!timedOut) begin
            @(negedge clk);
            cmdPhase = phase;
            cmdDuty = duty;
            cmdReq = 1'b1;
            n = 0;
            while (!cmdAck && n < HS_TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (!cmdAck) begin
                $display("timeout: cmdAck never rose after cmdReq");
                timedOut = 1'b1;
            end
            cmdReq = 1'b0;
            n = 0;
            while (cmdAck && n < HS_TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (cmdAck) begin
                $display("timeout: cmdAck stayed high after cmdReq dropped");
                timedOut = 1'b1;
            end
        end
    endtask

    task automatic waitFrames(input int count);
        int n;
        for (int f = 0; f < count && !timedOut; f++) begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!frameStart && n < FRAME_TIMEOUT);
            if (!frameStart) begin
                $display("timeout: no frameStart within %0d cycles", FRAME_TIMEOUT);
                timedOut = 1'b1;
            end
        end
    endtask

    task automatic reportTest(input string name);
        int fails;
        fails = errCount - testErrBase;
        testsRun++;
        if (fails != 0 || timedOut) begin
            testsFailed++;
        end
        $display("test %0d %s: %s, %0d failed checks", testsRun, name,
                 (fails == 0 && !timedOut) ? "ok" : "failed", fails);
        testErrBase = errCount;
    endtask

    initial begin
        rstN = 1'b0;
        runEn = 1'b0;
        cmdReq = 1'b0;
        cmdPhase = '0;
        cmdDuty = '0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        repeat (300) @(negedge clk);
        reportTest("reset and idle");
        // handshakes while parked, phase 3 must vanish
        for (int i = 0; i < 6; i++) begin
            sendCmd(2'(randBits(2)), randBits(8));
        end
        sendCmd(2'd3, 8'hFF);
        reportTest("handshake");
        @(negedge clk);
        runEn = 1'b1;
        sendCmd(2'd0, 8'd100);
        sendCmd(2'd1, randBits(8) | 8'h20);
        sendCmd(2'd2, randBits(8) | 8'h20);
        // phase 3 right behind them must leave all three duties alone
        sendCmd(2'd3, 8'hFF);
        waitFrames(2);
        reportTest("plain duty and frame latching");
        // 6 + 6 + 6 gives an 18 cycle pulse every third live period
        sendCmd(2'd0, 8'd6);
        waitFrames(5);
        reportTest("minimum-pulse carry");
        sendCmd(2'd0, 8'd250);
        sendCmd(2'd1, 8'd250);
        sendCmd(2'd2, 8'd250);
        waitFrames(2);
        reportTest("clamp");
        waitFrames(6);
        reportTest("commutation");
        $display("tests run %0d, tests failed %0d, check failures %0d",
                 testsRun, testsFailed, errCount);
        if (errCount == 0 && !timedOut) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
